//--- hdl/cpu_width_pkg.sv
package cpu_width_pkg;

    // fixed field widths of the core
    parameter int PC_WIDTH       = 32;
    parameter int INST_WIDTH     = 32;
    parameter int REG_ADDR_WIDTH = 5;   // 32 gprs

endpackage

//--- hdl/cpu_op_pkg.sv
package cpu_op_pkg;

    parameter int ALU_OP_WIDTH = 4;
    parameter int LSU_OP_WIDTH = 3;

    typedef enum logic [ALU_OP_WIDTH-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_MULH,   // upper half, unsigned
        ALU_DIV,
        ALU_MOD
    } alu_op_e;

    // only carried through execute
    typedef enum logic [LSU_OP_WIDTH-1:0] {
        LSU_NONE,
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_op_e;

endpackage

//--- hdl/id_stage_if.sv
interface id_stage_if #(
    parameter int data_width = 32
);

    logic                                     valid;
    logic                                     ready;
    logic [cpu_width_pkg::PC_WIDTH-1:0]       pc;
    logic [cpu_width_pkg::INST_WIDTH-1:0]     inst;
    cpu_op_pkg::alu_op_e                      alu_op;
    logic [data_width-1:0]                    oprand1;
    logic [data_width-1:0]                    oprand2;
    cpu_op_pkg::lsu_op_e                      lsu_op;
    logic [data_width-1:0]                    lsu_data;   // store data
    logic                                     rw_en;
    logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] rw_addr;

    // latch side
    modport o (
        output valid, pc, inst, alu_op, oprand1, oprand2,
        output lsu_op, lsu_data, rw_en, rw_addr,
        input  ready
    );

    // execute side
    modport i (
        input  valid, pc, inst, alu_op, oprand1, oprand2,
        input  lsu_op, lsu_data, rw_en, rw_addr,
        output ready
    );

endinterface

//--- hdl/ex_stage_if.sv
interface ex_stage_if #(
    parameter int data_width = 32
);

    logic                                     valid;
    logic                                     ready;
    logic [cpu_width_pkg::PC_WIDTH-1:0]       pc;
    logic [cpu_width_pkg::INST_WIDTH-1:0]     inst;
    logic [data_width-1:0]                    ex_result;
    cpu_op_pkg::lsu_op_e                      lsu_op;
    logic [data_width-1:0]                    lsu_data;
    logic                                     rw_en;
    logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] rw_addr;

    modport o (
        output valid, pc, inst, ex_result, lsu_op, lsu_data, rw_en, rw_addr,
        input  ready
    );

    modport i (
        input  valid, pc, inst, ex_result, lsu_op, lsu_data, rw_en, rw_addr,
        output ready
    );

endinterface

//--- hdl/alu.sv
module alu #(
    parameter int data_width = 32
) (
    input  cpu_op_pkg::alu_op_e   op,
    input  logic [data_width-1:0] oprand1,
    input  logic [data_width-1:0] oprand2,
    output logic [data_width-1:0] result
);

    localparam int shamt_width = $clog2(data_width);

    logic [shamt_width-1:0]  shamt;
    logic [2*data_width-1:0] product;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic                    div_zero;

    assign shamt       = oprand2[shamt_width-1:0];   // low bits only
    assign lt_signed   = $signed(oprand1) < $signed(oprand2);
    assign lt_unsigned = oprand1 < oprand2;
    assign div_zero    = (oprand2 == '0);

    // full width product, zero extended
    assign product = {{data_width{1'b0}}, oprand1} * {{data_width{1'b0}}, oprand2};

    always_comb
    begin
        case (op)
            cpu_op_pkg::ALU_ADD:
                result = oprand1 + oprand2;   // wraps
            cpu_op_pkg::ALU_SUB:
                result = oprand1 - oprand2;
            cpu_op_pkg::ALU_AND:
                result = oprand1 & oprand2;
            cpu_op_pkg::ALU_OR:
                result = oprand1 | oprand2;
            cpu_op_pkg::ALU_XOR:
                result = oprand1 ^ oprand2;
            cpu_op_pkg::ALU_NOR:
                result = ~(oprand1 | oprand2);
            cpu_op_pkg::ALU_SLL:
                result = oprand1 << shamt;
            cpu_op_pkg::ALU_SRL:
                result = oprand1 >> shamt;
            cpu_op_pkg::ALU_SRA:
                result = $signed(oprand1) >>> shamt;   // sign fill
            cpu_op_pkg::ALU_SLT:
                result = {{(data_width-1){1'b0}}, lt_signed};
            cpu_op_pkg::ALU_SLTU:
                result = {{(data_width-1){1'b0}}, lt_unsigned};
            cpu_op_pkg::ALU_MUL:
                result = product[data_width-1:0];
            cpu_op_pkg::ALU_MULH:
                result = product[2*data_width-1:data_width];
            cpu_op_pkg::ALU_DIV:
                result = div_zero ? '1 : oprand1 / oprand2;   // all ones on /0
            cpu_op_pkg::ALU_MOD:
                result = div_zero ? oprand1 : oprand1 % oprand2;
            default:
                result = '0;   // unused encoding
        endcase
    end

endmodule

//--- hdl/id_latch.sv
module id_latch #(
    parameter int data_width = 32
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_req,
    output logic                                     in_ack,
    input  logic [cpu_width_pkg::PC_WIDTH-1:0]       in_pc,
    input  logic [cpu_width_pkg::INST_WIDTH-1:0]     in_inst,
    input  cpu_op_pkg::alu_op_e                      in_alu_op,
    input  logic [data_width-1:0]                    in_oprand1,
    input  logic [data_width-1:0]                    in_oprand2,
    input  cpu_op_pkg::lsu_op_e                      in_lsu_op,
    input  logic [data_width-1:0]                    in_lsu_data,
    input  logic                                     in_rw_en,
    input  logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] in_rw_addr,
    id_stage_if.o                                    id_info
);

    // IDLE is always empty, WAIT_DROP holds an item after the handshake
    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        WAIT_DROP
    } state_e;

    state_e state;
    logic   capture;
    logic   take;

    assign capture = (state == IDLE) && in_req;
    assign take    = id_info.valid && id_info.ready;   // execute accepts
    assign in_ack  = (state == ACKED);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= IDLE;
            id_info.valid <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (in_req)
                        state <= ACKED;
                ACKED:
                    if (!in_req)
                        state <= (id_info.valid && !take) ? WAIT_DROP : IDLE;
                WAIT_DROP:
                    if (take)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase

            if (capture)
                id_info.valid <= 1'b1;
            else if (take)
                id_info.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            id_info.pc       <= in_pc;
            id_info.inst     <= in_inst;
            id_info.alu_op   <= in_alu_op;
            id_info.oprand1  <= in_oprand1;
            id_info.oprand2  <= in_oprand2;
            id_info.lsu_op   <= in_lsu_op;
            id_info.lsu_data <= in_lsu_data;
            id_info.rw_en    <= in_rw_en;
            id_info.rw_addr  <= in_rw_addr;
        end
    end

endmodule

//--- hdl/execute.sv
module execute #(
    parameter int data_width = 32
) (
    input  logic  clk,
    input  logic  rst_n,
    id_stage_if.i id_info,
    ex_stage_if.o ex_info
);

    logic [data_width-1:0] alu_res;
    logic                  take;

    alu #(
        .data_width(data_width)
    ) alu_0 (
        .op      (id_info.alu_op),
        .oprand1 (id_info.oprand1),
        .oprand2 (id_info.oprand2),
        .result  (alu_res)
    );

    // empty, or draining on this edge
    assign id_info.ready = !ex_info.valid || ex_info.ready;
    assign take          = id_info.valid && id_info.ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_info.valid <= 1'b0;
        end
        else if (take)
        begin
            ex_info.valid <= 1'b1;
        end
        else if (ex_info.ready)
        begin
            ex_info.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            ex_info.ex_result <= alu_res;
            ex_info.pc        <= id_info.pc;
            ex_info.inst      <= id_info.inst;
            ex_info.lsu_op    <= id_info.lsu_op;   // passed through
            ex_info.lsu_data  <= id_info.lsu_data;
            ex_info.rw_en     <= id_info.rw_en;
            ex_info.rw_addr   <= id_info.rw_addr;
        end
    end

endmodule

//--- hdl/wb_sender.sv
module wb_sender #(
    parameter int data_width = 32
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    ex_stage_if.i                                    ex_info,
    input  logic                                     out_ack,
    output logic                                     out_req,
    output logic [cpu_width_pkg::PC_WIDTH-1:0]       out_pc,
    output logic [cpu_width_pkg::INST_WIDTH-1:0]     out_inst,
    output logic [data_width-1:0]                    out_ex_result,
    output cpu_op_pkg::lsu_op_e                      out_lsu_op,
    output logic [data_width-1:0]                    out_lsu_data,
    output logic                                     out_rw_en,
    output logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] out_rw_addr
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } state_e;

    state_e state;
    logic   take;

    assign ex_info.ready = (state == IDLE);   // one item in flight
    assign take          = ex_info.valid && ex_info.ready;
    assign out_req       = (state == REQ);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                    if (ex_info.valid)
                        state <= REQ;
                REQ:
                    if (out_ack)
                        state <= WAIT_ACK_LOW;
                WAIT_ACK_LOW:
                    if (!out_ack)
                        state <= IDLE;   // return to zero done
                default:
                    state <= IDLE;
            endcase
        end
    end

    // held for the whole exchange
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            out_pc        <= ex_info.pc;
            out_inst      <= ex_info.inst;
            out_ex_result <= ex_info.ex_result;
            out_lsu_op    <= ex_info.lsu_op;
            out_lsu_data  <= ex_info.lsu_data;
            out_rw_en     <= ex_info.rw_en;
            out_rw_addr   <= ex_info.rw_addr;
        end
    end

endmodule

//--- hdl/exec_unit_top.sv
module exec_unit_top #(
    parameter int data_width = 32
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // input port, four-phase
    input  logic                                     in_req,
    output logic                                     in_ack,
    input  logic [cpu_width_pkg::PC_WIDTH-1:0]       in_pc,
    input  logic [cpu_width_pkg::INST_WIDTH-1:0]     in_inst,
    input  cpu_op_pkg::alu_op_e                      in_alu_op,
    input  logic [data_width-1:0]                    in_oprand1,
    input  logic [data_width-1:0]                    in_oprand2,
    input  cpu_op_pkg::lsu_op_e                      in_lsu_op,
    input  logic [data_width-1:0]                    in_lsu_data,
    input  logic                                     in_rw_en,
    input  logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] in_rw_addr,
    // output port, four-phase
    output logic                                     out_req,
    input  logic                                     out_ack,
    output logic [cpu_width_pkg::PC_WIDTH-1:0]       out_pc,
    output logic [cpu_width_pkg::INST_WIDTH-1:0]     out_inst,
    output logic [data_width-1:0]                    out_ex_result,
    output cpu_op_pkg::lsu_op_e                      out_lsu_op,
    output logic [data_width-1:0]                    out_lsu_data,
    output logic                                     out_rw_en,
    output logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] out_rw_addr
);

    id_stage_if #(.data_width(data_width)) id_bus ();
    ex_stage_if #(.data_width(data_width)) ex_bus ();

    id_latch #(
        .data_width(data_width)
    ) id_latch_0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_ack      (in_ack),
        .in_pc       (in_pc),
        .in_inst     (in_inst),
        .in_alu_op   (in_alu_op),
        .in_oprand1  (in_oprand1),
        .in_oprand2  (in_oprand2),
        .in_lsu_op   (in_lsu_op),
        .in_lsu_data (in_lsu_data),
        .in_rw_en    (in_rw_en),
        .in_rw_addr  (in_rw_addr),
        .id_info     (id_bus.o)
    );

    execute #(
        .data_width(data_width)
    ) execute_0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .id_info (id_bus.i),
        .ex_info (ex_bus.o)
    );

    wb_sender #(
        .data_width(data_width)
    ) wb_sender_0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_info       (ex_bus.i),
        .out_ack       (out_ack),
        .out_req       (out_req),
        .out_pc        (out_pc),
        .out_inst      (out_inst),
        .out_ex_result (out_ex_result),
        .out_lsu_op    (out_lsu_op),
        .out_lsu_data  (out_lsu_data),
        .out_rw_en     (out_rw_en),
        .out_rw_addr   (out_rw_addr)
    );

endmodule

//--- test/exec_unit_checker.sv
module exec_unit_checker #(
    parameter int data_width = 32
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_ack,
    input  logic [cpu_width_pkg::PC_WIDTH-1:0]       in_pc,
    input  logic [cpu_width_pkg::INST_WIDTH-1:0]     in_inst,
    input  cpu_op_pkg::alu_op_e                      in_alu_op,
    input  logic [data_width-1:0]                    in_oprand1,
    input  logic [data_width-1:0]                    in_oprand2,
    input  cpu_op_pkg::lsu_op_e                      in_lsu_op,
    input  logic [data_width-1:0]                    in_lsu_data,
    input  logic                                     in_rw_en,
    input  logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] in_rw_addr,
    input  logic                                     out_req,
    input  logic                                     out_ack,
    input  logic [cpu_width_pkg::PC_WIDTH-1:0]       out_pc,
    input  logic [cpu_width_pkg::INST_WIDTH-1:0]     out_inst,
    input  logic [data_width-1:0]                    out_ex_result,
    input  cpu_op_pkg::lsu_op_e                      out_lsu_op,
    input  logic [data_width-1:0]                    out_lsu_data,
    input  logic                                     out_rw_en,
    input  logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] out_rw_addr,
    output int                                       mismatch_count,
    output int                                       error_count,
    output int                                       out_count
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sh_width = $clog2(data_width);

    typedef struct packed {
        logic [cpu_width_pkg::PC_WIDTH-1:0]       pc;
        logic [cpu_width_pkg::INST_WIDTH-1:0]     inst;
        logic [data_width-1:0]                    result;
        cpu_op_pkg::lsu_op_e                      lsu_op;
        logic [data_width-1:0]                    lsu_data;
        logic                                     rw_en;
        logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] rw_addr;
    } expect_t;

    expect_t expect_q[$];   // oldest first
    int      mismatches  = 0;
    int      errors      = 0;
    int      outputs     = 0;
    logic    in_ack_q    = 1'b0;
    logic    out_req_q   = 1'b0;
    logic    after_reset = 1'b0;

    assign mismatch_count = mismatches;
    assign error_count    = errors;
    assign out_count      = outputs;

    function automatic logic [data_width-1:0] model_result(
        cpu_op_pkg::alu_op_e op, logic [data_width-1:0] a, logic [data_width-1:0] b);
        logic [2*data_width-1:0] acc;
        logic [data_width-1:0]   quo;
        logic [data_width:0]     rem;
        logic                    lt;
        int                      sh;
        sh  = int'(b[sh_width-1:0]);
        lt  = (a[data_width-1] != b[data_width-1]) ? a[data_width-1] : (a < b);
        acc = '0;
        for (int i = 0; i < data_width; i++)   // shift and add product
            if (b[i])
                acc = acc + ({{data_width{1'b0}}, a} << i);
        quo = '0;
        rem = '0;
        for (int i = data_width - 1; i >= 0; i--)   // restoring long division
        begin
            rem = {rem[data_width-1:0], a[i]};
            if (rem >= {1'b0, b})
            begin
                rem    = rem - {1'b0, b};
                quo[i] = 1'b1;
            end
        end
        case (op)
            cpu_op_pkg::ALU_ADD:  return a + b;
            cpu_op_pkg::ALU_SUB:  return a + ~b + data_width'(1);
            cpu_op_pkg::ALU_AND:  return a & b;
            cpu_op_pkg::ALU_OR:   return a | b;
            cpu_op_pkg::ALU_XOR:  return a ^ b;
            cpu_op_pkg::ALU_NOR:  return ~a & ~b;
            cpu_op_pkg::ALU_SLL:  return a << sh;
            cpu_op_pkg::ALU_SRL:  return a >> sh;
            cpu_op_pkg::ALU_SRA:  return (a >> sh) | (a[data_width-1] ? ~('1 >> sh) : '0);
            cpu_op_pkg::ALU_SLT:  return {{(data_width-1){1'b0}}, lt};
            cpu_op_pkg::ALU_SLTU: return {{(data_width-1){1'b0}}, a < b};
            cpu_op_pkg::ALU_MUL:  return acc[data_width-1:0];
            cpu_op_pkg::ALU_MULH: return acc[2*data_width-1:data_width];
            cpu_op_pkg::ALU_DIV:  return (b == '0) ? '1 : quo;
            cpu_op_pkg::ALU_MOD:  return (b == '0) ? a : rem[data_width-1:0];
            default:              return '0;
        endcase
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        expect_t item;
        if (!rst_n)
        begin
            if (in_ack || out_req)
            begin
                $display("at %0t in_ack or out_req is high while reset is held", $time);
                errors++;
            end
            in_ack_q    = 1'b0;
            out_req_q   = 1'b0;
            after_reset = 1'b1;
        end
        else
        begin
            if (after_reset && (in_ack || out_req))
            begin
                $display("at %0t in_ack or out_req is high right after reset", $time);
                errors++;
            end
            after_reset = 1'b0;
            if (in_ack && !in_ack_q)
            begin
                item.pc       = in_pc;
                item.inst     = in_inst;
                item.result   = model_result(in_alu_op, in_oprand1, in_oprand2);
                item.lsu_op   = in_lsu_op;
                item.lsu_data = in_lsu_data;
                item.rw_en    = in_rw_en;
                item.rw_addr  = in_rw_addr;
                expect_q.push_back(item);
            end
            if (out_req && !out_req_q)
            begin
                outputs++;
                if (out_ack)
                begin
                    $display("at %0t out_req rose while out_ack was still high", $time);
                    errors++;
                end
                if (expect_q.size() == 0)
                begin
                    $display("at %0t an output appeared with no instruction pending", $time);
                    errors++;
                end
                else
                begin
                    item = expect_q.pop_front();
                    check_field("out_pc", 64'(out_pc), 64'(item.pc));
                    check_field("out_inst", 64'(out_inst), 64'(item.inst));
                    check_field("out_ex_result", 64'(out_ex_result), 64'(item.result));
                    check_field("out_lsu_op", 64'(out_lsu_op), 64'(item.lsu_op));
                    check_field("out_lsu_data", 64'(out_lsu_data), 64'(item.lsu_data));
                    check_field("out_rw_en", 64'(out_rw_en), 64'(item.rw_en));
                    check_field("out_rw_addr", 64'(out_rw_addr), 64'(item.rw_addr));
                end
            end
            in_ack_q  = in_ack;
            out_req_q = out_req;
        end
    end

endmodule

//--- test/exec_unit_tb.sv
module exec_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int data_width  = 32;
    localparam int num_insts   = 400;
    localparam int cycle_limit = num_insts * 24 + 100;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     in_req;
    logic                                     in_ack;
    logic [cpu_width_pkg::PC_WIDTH-1:0]       in_pc;
    logic [cpu_width_pkg::INST_WIDTH-1:0]     in_inst;
    cpu_op_pkg::alu_op_e                      in_alu_op;
    logic [data_width-1:0]                    in_oprand1;
    logic [data_width-1:0]                    in_oprand2;
    cpu_op_pkg::lsu_op_e                      in_lsu_op;
    logic [data_width-1:0]                    in_lsu_data;
    logic                                     in_rw_en;
    logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] in_rw_addr;
    logic                                     out_req;
    logic                                     out_ack;
    logic [cpu_width_pkg::PC_WIDTH-1:0]       out_pc;
    logic [cpu_width_pkg::INST_WIDTH-1:0]     out_inst;
    logic [data_width-1:0]                    out_ex_result;
    cpu_op_pkg::lsu_op_e                      out_lsu_op;
    logic [data_width-1:0]                    out_lsu_data;
    logic                                     out_rw_en;
    logic [cpu_width_pkg::REG_ADDR_WIDTH-1:0] out_rw_addr;
    int                                       mismatch_count;
    int                                       error_count;
    int                                       out_count;

    integer seed = 66411;
    int     cycles;
    int     tb_errors;

    exec_unit_top #(.data_width(data_width)) exec_unit_top_i (.*);
    exec_unit_checker #(.data_width(data_width)) checker_i (.*);

    // corner values get an extra share
    function automatic logic [data_width-1:0] pick_operand();
        logic [63:0] r;
        int          sel;
        sel = int'({$random(seed)} % 32'd8);
        r   = {$random(seed), $random(seed)};
        case (sel)
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(data_width-1){1'b0}}};
            3:       return {1'b0, {(data_width-1){1'b1}}};
            default: return r[data_width-1:0];
        endcase
    endfunction

    task automatic send_inst(input int idx);
        logic [31:0] pick;
        int          gap;
        gap = int'({$random(seed)} % 32'd3);
        repeat (gap) @(posedge clk);
        in_pc       <= 32'h1c00_0000 + 32'(idx) * 32'd4;
        in_inst     <= $random(seed);
        pick = $random(seed);
        in_alu_op   <= cpu_op_pkg::alu_op_e'(4'(pick % 32'd15));
        pick = $random(seed);
        in_lsu_op   <= cpu_op_pkg::lsu_op_e'(3'(pick % 32'd7));
        pick = $random(seed);
        in_rw_en    <= pick[0];
        in_rw_addr  <= pick[5:1];
        in_oprand1  <= pick_operand();
        in_oprand2  <= pick_operand();
        in_lsu_data <= pick_operand();
        in_req      <= 1'b1;
        do @(posedge clk); while (!in_ack);
        in_req <= 1'b0;
        do @(posedge clk); while (in_ack);   // return to zero
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // output side, random back-pressure
    initial
    begin
        int delay;
        out_ack = 1'b0;
        forever
        begin
            do @(posedge clk); while (!out_req);
            delay = int'({$random(seed)} % 32'd7);
            repeat (delay) @(posedge clk);
            out_ack <= 1'b1;
            do @(posedge clk); while (out_req);
            delay = int'({$random(seed)} % 32'd7);
            repeat (delay) @(posedge clk);
            out_ack <= 1'b0;
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not complete within %0d cycles", cycle_limit);
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        tb_errors   = 0;
        rst_n       = 1'b0;
        in_req      = 1'b0;
        in_pc       = '0;
        in_inst     = '0;
        in_alu_op   = cpu_op_pkg::ALU_ADD;
        in_oprand1  = '0;
        in_oprand2  = '0;
        in_lsu_op   = cpu_op_pkg::LSU_NONE;
        in_lsu_data = '0;
        in_rw_en    = 1'b0;
        in_rw_addr  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < num_insts; i++)
            send_inst(i);
        while (out_count < num_insts) @(posedge clk);
        repeat (20) @(posedge clk);   // catch stray outputs
        if (out_count != num_insts)
        begin
            $display("output count is %0d instead of %0d", out_count, num_insts);
            tb_errors++;
        end
        $display("mismatches: %0d, errors: %0d, outputs: %0d",
                 mismatch_count, error_count + tb_errors, out_count);
        if (mismatch_count + error_count + tb_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- vlog.f
hdl/cpu_width_pkg.sv
hdl/cpu_op_pkg.sv
hdl/id_stage_if.sv
hdl/ex_stage_if.sv
hdl/alu.sv
hdl/id_latch.sv
hdl/execute.sv
hdl/wb_sender.sv
hdl/exec_unit_top.sv
test/exec_unit_checker.sv
test/exec_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module exec_unit_tb -Mdir obj_dir -o exec_unit_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/exec_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
